// File: design/camera_macros.svh
//////////////////////////////////////////////////////////////////////
// Capture subsystem constants
// Crop window, binned image size, op-codes and metering shift
//////////////////////////////////////////////////////////////////////
`ifndef CAMERA_MACROS_SVH
`define CAMERA_MACROS_SVH

`define CROP_X_START 2      // Column range, end exclusive
`define CROP_X_END   10
`define CROP_Y_START 1
`define CROP_Y_END   9

`define BIN_WIDTH    4      // Binned pixels per line
`define BIN_PIXELS   16     // Binned pixels per frame
`define METER_SHIFT  4      // log2 of BIN_PIXELS
`define BUF_WORDS    16

`define OP_CAPTURE   8'h20
`define OP_READ      8'h22
`define OP_METER     8'h25
`define OP_STATUS    8'h27
`define OP_SIZE      8'h28

`endif

// File: design/camera_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the capture pipeline
// Pixel and address widths, stream structs, capture states
//////////////////////////////////////////////////////////////////////
package camera_pkg;

    typedef logic [9:0]  raw_pixel_t;   // Raw sensor sample
    typedef logic [7:0]  colour_t;
    typedef logic [3:0]  word_addr_t;   // Image buffer word
    typedef logic [5:0]  byte_addr_t;   // Image byte
    typedef logic [10:0] coord_x_t;
    typedef logic [9:0]  coord_y_t;

    // Bayer stream with sensor strobes
    typedef struct packed {
        logic       frame_valid;
        logic       line_valid;
        raw_pixel_t pixel;
    } raw_stream_t;

    typedef struct packed {
        logic    frame_valid;
        logic    pixel_valid;
        colour_t red;
        colour_t green;
        colour_t blue;
    } rgb_stream_t;

    typedef struct packed {
        logic        we;
        word_addr_t  addr;
        logic [31:0] data;
    } buf_write_t;

    typedef enum logic [1:0] {IDLE, ARMED, ACTIVE, DONE} capture_state_t;

endpackage

// File: design/camera_crop.sv
//////////////////////////////////////////////////////////////////////
// Crop window
// Column and line counters, keeps the pixels inside the fixed
// window and rebuilds the line and frame strobes
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module camera_crop (
    input  logic                    clock_spi_in,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::raw_stream_t raw_i,
    output camera_pkg::raw_stream_t raw_o
);

    camera_pkg::coord_x_t x_count;
    camera_pkg::coord_y_t y_count;
    logic line_valid_d;
    logic in_window;

    assign in_window = raw_i.line_valid &&
                       x_count >= `CROP_X_START && x_count < `CROP_X_END &&
                       y_count >= `CROP_Y_START && y_count < `CROP_Y_END;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count      <= '0;
            y_count      <= '0;
            line_valid_d <= 1'b0;
            raw_o        <= '0;
        end else begin
            line_valid_d <= raw_i.line_valid;

            if (raw_i.line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
            end

            // Next line after each line end
            if (!raw_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_d && !raw_i.line_valid) begin
                y_count <= y_count + 1'b1;
            end

            raw_o.frame_valid <= raw_i.frame_valid;  // Keeps alignment
            raw_o.line_valid  <= in_window;
            raw_o.pixel       <= raw_i.pixel;
        end
    end

endmodule

// File: design/bayer_binning.sv
//////////////////////////////////////////////////////////////////////
// 2x2 RGGB binning
// Half-line buffer of R/G pairs from even lines, combined with
// the G/B pairs of the odd lines into one RGB pixel
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module bayer_binning (
    input  logic                    clock_spi_in,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::raw_stream_t raw_i,
    output camera_pkg::rgb_stream_t rgb_o
);

    localparam int IDX_W = $clog2(`BIN_WIDTH);

    logic [IDX_W-1:0] pair_idx;
    logic odd_col;
    logic odd_line;
    logic line_valid_d;
    logic [10:0] green_sum;

    camera_pkg::raw_pixel_t first_q;  // First pixel of current pair
    camera_pkg::raw_pixel_t red_buf [`BIN_WIDTH];
    camera_pkg::raw_pixel_t green_buf [`BIN_WIDTH];

    assign green_sum = {1'b0, green_buf[pair_idx]} + {1'b0, first_q};

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pair_idx     <= '0;
            odd_col      <= 1'b0;
            odd_line     <= 1'b0;
            line_valid_d <= 1'b0;
            rgb_o        <= '0;
        end else begin
            line_valid_d      <= raw_i.line_valid;
            rgb_o.frame_valid <= raw_i.frame_valid;
            rgb_o.pixel_valid <= raw_i.line_valid && odd_col && odd_line;

            if (!raw_i.frame_valid) begin
                odd_line <= 1'b0;
            end else if (line_valid_d && !raw_i.line_valid) begin
                odd_line <= !odd_line;
            end

            if (raw_i.line_valid) begin
                odd_col <= !odd_col;
                if (odd_col) begin
                    pair_idx <= pair_idx + 1'b1;
                end
            end else begin
                odd_col  <= 1'b0;
                pair_idx <= '0;
            end

            // B arrives, finish the block
            if (raw_i.line_valid && odd_col && odd_line) begin
                rgb_o.red   <= red_buf[pair_idx][9:2];
                rgb_o.green <= green_sum[10:3];  // Mean of both greens, top 8 bits
                rgb_o.blue  <= raw_i.pixel[9:2];
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (raw_i.line_valid) begin
            if (!odd_col) begin
                first_q <= raw_i.pixel;
            end else if (!odd_line) begin
                red_buf[pair_idx]   <= first_q;
                green_buf[pair_idx] <= raw_i.pixel;
            end
        end
    end

endmodule

// File: design/exposure_metering.sv
//////////////////////////////////////////////////////////////////////
// Exposure metering
// Per-frame colour sums of the binned stream, averages latched
// at frame end
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module exposure_metering (
    input  logic                    clock_spi_in,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::rgb_stream_t rgb_i,
    output camera_pkg::colour_t     red_o,
    output camera_pkg::colour_t     green_o,
    output camera_pkg::colour_t     blue_o
);

    localparam int SUM_W = 8 + $clog2(`BIN_PIXELS);

    logic [SUM_W-1:0] red_sum;
    logic [SUM_W-1:0] green_sum;
    logic [SUM_W-1:0] blue_sum;
    logic frame_valid_d;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
            frame_valid_d <= 1'b0;
            red_o         <= '0;
            green_o       <= '0;
            blue_o        <= '0;
        end else begin
            frame_valid_d <= rgb_i.frame_valid;
            if (rgb_i.frame_valid && !frame_valid_d) begin  // Frame start
                red_sum   <= '0;
                green_sum <= '0;
                blue_sum  <= '0;
            end else if (rgb_i.pixel_valid) begin
                red_sum   <= red_sum + SUM_W'(rgb_i.red);
                green_sum <= green_sum + SUM_W'(rgb_i.green);
                blue_sum  <= blue_sum + SUM_W'(rgb_i.blue);
            end
            if (frame_valid_d && !rgb_i.frame_valid) begin
                red_o   <= red_sum[`METER_SHIFT +: 8];
                green_o <= green_sum[`METER_SHIFT +: 8];
                blue_o  <= blue_sum[`METER_SHIFT +: 8];
            end
        end
    end

endmodule

// File: design/pixel_packer.sv
//////////////////////////////////////////////////////////////////////
// RGB to 32-bit word packer
// Three bytes per pixel, first byte in the low lane, partial word
// flushed at frame end, image byte counter
//////////////////////////////////////////////////////////////////////
module pixel_packer (
    input  logic                    clock_spi_in,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::rgb_stream_t rgb_i,
    input  logic                    capture_active_i,
    output camera_pkg::buf_write_t  wr_o,
    output camera_pkg::byte_addr_t  byte_count_o
);

    logic [1:0]  fill;     // Bytes waiting in pending
    logic [23:0] pending;
    logic [47:0] merged;
    logic frame_valid_d;
    logic active_d;
    camera_pkg::word_addr_t wr_addr;

    assign merged = {24'b0, pending} |
                    ({24'b0, rgb_i.blue, rgb_i.green, rgb_i.red} << (8 * fill));

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            fill          <= '0;
            pending       <= '0;
            frame_valid_d <= 1'b0;
            active_d      <= 1'b0;
            wr_addr       <= '0;
            wr_o          <= '0;
            byte_count_o  <= '0;
        end else begin
            frame_valid_d <= rgb_i.frame_valid;
            active_d      <= capture_active_i;
            wr_o.we       <= 1'b0;

            if (capture_active_i && !active_d) begin  // New capture
                fill         <= '0;
                pending      <= '0;
                wr_addr      <= '0;
                byte_count_o <= '0;
            end else if (capture_active_i && rgb_i.pixel_valid) begin
                byte_count_o <= byte_count_o + 6'd3;
                if (fill == 2'd0) begin
                    pending <= merged[23:0];
                    fill    <= 2'd3;
                end else begin
                    wr_o.we   <= 1'b1;
                    wr_o.addr <= wr_addr;
                    wr_o.data <= merged[31:0];
                    wr_addr   <= wr_addr + 1'b1;
                    pending   <= {8'b0, merged[47:32]};  // Leftover bytes
                    fill      <= fill - 2'd1;
                end
            end else if (capture_active_i && frame_valid_d && !rgb_i.frame_valid &&
                         fill != 2'd0) begin
                wr_o.we   <= 1'b1;
                wr_o.addr <= wr_addr;
                wr_o.data <= {8'b0, pending};
                wr_addr   <= wr_addr + 1'b1;
                pending   <= '0;
                fill      <= '0;
            end
        end
    end

endmodule

// File: design/image_buffer.sv
//////////////////////////////////////////////////////////////////////
// Image buffer
// Word-wide write port, registered byte read port
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module image_buffer (
    input  logic                   clock_spi_in,
    input  camera_pkg::buf_write_t wr_i,
    input  camera_pkg::byte_addr_t read_addr_i,
    output camera_pkg::colour_t    read_data_o
);

    logic [31:0] mem [`BUF_WORDS];
    camera_pkg::word_addr_t read_word;

    assign read_word = read_addr_i[5:2];

    always_ff @(posedge clock_spi_in) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        read_data_o <= mem[read_word][8 * read_addr_i[1:0] +: 8];  // Byte lane select
    end

endmodule

// File: design/capture_control.sv
//////////////////////////////////////////////////////////////////////
// Command control
// Op-code decode, capture FSM, read address and response register
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module capture_control (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  logic [7:0]             op_code_i,
    input  logic                   op_code_valid_i,
    input  logic [7:0]             operand_i,
    input  logic                   operand_valid_i,
    input  logic [1:0]             operand_count_i,
    output logic [7:0]             response_o,
    output logic                   response_valid_o,
    input  logic                   frame_valid_i,
    input  logic                   binned_frame_valid_i,
    input  camera_pkg::colour_t    red_i,
    input  camera_pkg::colour_t    green_i,
    input  camera_pkg::colour_t    blue_i,
    input  camera_pkg::byte_addr_t byte_count_i,
    input  camera_pkg::colour_t    read_data_i,
    output camera_pkg::byte_addr_t read_addr_o,
    output logic                   capture_active_o
);

    camera_pkg::capture_state_t state;
    logic frame_valid_d;
    logic binned_frame_valid_d;
    logic operand_valid_d;

    assign capture_active_o = (state == camera_pkg::ACTIVE);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state                <= camera_pkg::IDLE;
            frame_valid_d        <= 1'b0;
            binned_frame_valid_d <= 1'b0;
            operand_valid_d      <= 1'b0;
            read_addr_o          <= '0;
            response_o           <= '0;
            response_valid_o     <= 1'b0;
        end else begin
            frame_valid_d        <= frame_valid_i;
            binned_frame_valid_d <= binned_frame_valid_i;
            operand_valid_d      <= operand_valid_i;

            case (state)
                camera_pkg::ARMED:  // A rise implies a low cycle was seen
                    if (frame_valid_i && !frame_valid_d) begin
                        state <= camera_pkg::ACTIVE;
                    end
                camera_pkg::ACTIVE:
                    if (binned_frame_valid_d && !binned_frame_valid_i) begin
                        state <= camera_pkg::DONE;
                    end
                default: ;
            endcase

            if (op_code_valid_i) begin
                case (op_code_i)
                    `OP_CAPTURE: begin
                        if (state != camera_pkg::ACTIVE) begin
                            state <= camera_pkg::ARMED;
                        end
                        read_addr_o <= '0;
                    end
                    `OP_READ: begin
                        response_o       <= read_data_i;
                        response_valid_o <= 1'b1;
                        if (operand_valid_i && !operand_valid_d) begin
                            read_addr_o <= read_addr_o + 1'b1;
                        end
                    end
                    `OP_METER: begin
                        case (operand_count_i)
                            2'd0:    response_o <= red_i;
                            2'd1:    response_o <= green_i;
                            2'd2:    response_o <= blue_i;
                            default: response_o <= '0;
                        endcase
                        response_valid_o <= 1'b1;
                    end
                    `OP_STATUS: begin
                        response_o       <= {7'b0, state == camera_pkg::DONE};
                        response_valid_o <= 1'b1;
                    end
                    `OP_SIZE: begin
                        response_o       <= {2'b0, byte_count_i};
                        response_valid_o <= 1'b1;
                    end
                    default: ;
                endcase
            end else begin
                response_valid_o <= 1'b0;
            end
        end
    end

endmodule

// File: design/camera_top.sv
//////////////////////////////////////////////////////////////////////
// Capture subsystem top level
// Crop, binning, metering, packer, image buffer, command control
//////////////////////////////////////////////////////////////////////
module camera_top (
    input  logic                    clock_spi_in,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::raw_stream_t raw_i,
    input  logic [7:0]              op_code_i,
    input  logic                    op_code_valid_i,
    input  logic [7:0]              operand_i,
    input  logic                    operand_valid_i,
    input  logic [1:0]              operand_count_i,
    output logic [7:0]              response_o,
    output logic                    response_valid_o
);

    camera_pkg::raw_stream_t cropped;
    camera_pkg::rgb_stream_t binned;
    camera_pkg::buf_write_t  buf_wr;
    camera_pkg::byte_addr_t  byte_count;
    camera_pkg::byte_addr_t  read_addr;
    camera_pkg::colour_t     read_data;
    camera_pkg::colour_t     red_meter;
    camera_pkg::colour_t     green_meter;
    camera_pkg::colour_t     blue_meter;
    logic capture_active;

    camera_crop u_crop (
        .clock_spi_in, .mipi_byte_reset_n, .raw_i, .raw_o(cropped)
    );

    bayer_binning u_binning (
        .clock_spi_in, .mipi_byte_reset_n, .raw_i(cropped), .rgb_o(binned)
    );

    exposure_metering u_metering (
        .clock_spi_in, .mipi_byte_reset_n, .rgb_i(binned),
        .red_o(red_meter), .green_o(green_meter), .blue_o(blue_meter)
    );

    pixel_packer u_packer (
        .clock_spi_in, .mipi_byte_reset_n, .rgb_i(binned),
        .capture_active_i(capture_active), .wr_o(buf_wr), .byte_count_o(byte_count)
    );

    image_buffer u_buffer (
        .clock_spi_in, .wr_i(buf_wr), .read_addr_i(read_addr), .read_data_o(read_data)
    );

    capture_control u_control (
        .clock_spi_in, .mipi_byte_reset_n,
        .op_code_i, .op_code_valid_i, .operand_i, .operand_valid_i, .operand_count_i,
        .response_o, .response_valid_o,
        .frame_valid_i(raw_i.frame_valid), .binned_frame_valid_i(binned.frame_valid),
        .red_i(red_meter), .green_i(green_meter), .blue_i(blue_meter),
        .byte_count_i(byte_count), .read_data_i(read_data),
        .read_addr_o(read_addr), .capture_active_o(capture_active)
    );

endmodule

// File: verification/camera_checker.sv
//////////////////////////////////////////////////////////////////////
// Testbench checker for the capture subsystem
// Records the raw frames, reference model of crop and 2x2 binning,
// response comparison and per-test reporting
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module camera_checker #(
    parameter int FRAME_W = 16,
    parameter int FRAME_H = 12
) (
    input  logic                    clock_spi_in,
    input  logic                    mipi_byte_reset_n,
    input  camera_pkg::raw_stream_t raw_i,
    input  logic                    op_code_valid_i,
    input  logic [7:0]              response_i,
    input  logic                    response_valid_i,
    input  logic                    check_req_i,
    input  logic [7:0]              check_kind_i,    // Op-code of the response to check
    input  int                      check_index_i,
    input  int                      ref_frame_i,
    input  logic                    test_end_i,
    input  int                      test_id_i,
    output int                      error_count_o,
    output int                      check_count_o,
    output int                      tests_failed_o
);

    localparam int MAX_FRAMES = 8;

    camera_pkg::raw_pixel_t frames [MAX_FRAMES][FRAME_H][FRAME_W];
    int   frame_cnt = 0;
    int   pos = 0;
    logic fv_d = 1'b0;
    bit   cmd_seen = 1'b0;
    int   errors = 0;
    int   checks = 0;
    int   failed = 0;
    int   errors_at_start = 0;
    int   checks_at_start = 0;

    assign error_count_o  = errors;
    assign check_count_o  = checks;
    assign tests_failed_o = failed;

    // Byte idx of the binned RGB image with the first R at the window corner
    function automatic logic [7:0] binned_byte(int f, int idx);
        int p;
        int r;
        int c;
        logic [10:0] g_sum;
        p = idx / 3;
        r = `CROP_Y_START + 2 * (p / `BIN_WIDTH);
        c = `CROP_X_START + 2 * (p % `BIN_WIDTH);
        g_sum = {1'b0, frames[f][r][c + 1]} + {1'b0, frames[f][r + 1][c]};
        case (idx % 3)
            0:       return frames[f][r][c][9:2];
            1:       return g_sum[10:3];             // Top 8 bits of the green mean
            default: return frames[f][r + 1][c + 1][9:2];
        endcase
    endfunction

    function automatic logic [7:0] frame_average(int f, int lane);
        int sum;
        sum = 0;
        for (int p = 0; p < `BIN_PIXELS; p++) begin
            sum += int'(binned_byte(f, 3 * p + lane));
        end
        return 8'(sum >> `METER_SHIFT);
    endfunction

    function automatic logic [7:0] reference_response(logic [7:0] kind, int index, int f);
        case (kind)
            `OP_READ:  return binned_byte(f, index);
            `OP_METER: return frame_average(f, index);
            `OP_SIZE:  return 8'(`BIN_PIXELS * 3);
            default:   return 8'(index);             // Status flag given by the sequence
        endcase
    endfunction

    // Raw frames as seen on the DUT input
    always @(negedge clock_spi_in) begin
        if (raw_i.frame_valid && !fv_d) pos = 0;
        if (raw_i.line_valid && frame_cnt < MAX_FRAMES && pos < FRAME_W * FRAME_H) begin
            frames[frame_cnt][pos / FRAME_W][pos % FRAME_W] = raw_i.pixel;
            pos++;
        end
        if (!raw_i.frame_valid && fv_d) frame_cnt++;
        fv_d = raw_i.frame_valid;
    end

    always @(negedge clock_spi_in) begin
        logic [7:0] expected;
        if (mipi_byte_reset_n) begin
            if (op_code_valid_i) cmd_seen = 1'b1;
            if (!cmd_seen && response_valid_i) begin
                errors++;
                cmd_seen = 1'b1;                     // Report only once
                $display("ERROR at time %0t: response_valid_o went high before any command",
                         $time);
            end
            if (check_req_i) begin
                expected = reference_response(check_kind_i, check_index_i, ref_frame_i);
                checks++;
                if (!response_valid_i) begin
                    errors++;
                    $display("ERROR at time %0t: no valid response to op 0x%02h",
                             $time, check_kind_i);
                end else if (response_i !== expected) begin
                    errors++;
                    $display("MISMATCH at %0t: op %02h index %0d gave %02h, expected %02h",
                             $time, check_kind_i, check_index_i, response_i, expected);
                end
            end
            if (test_end_i) begin
                if (errors == errors_at_start) begin
                    $display("test %0d passed, %0d checks", test_id_i, checks - checks_at_start);
                end else begin
                    failed++;
                    $display("test %0d FAILED, %0d errors", test_id_i, errors - errors_at_start);
                end
                errors_at_start = errors;
                checks_at_start = checks;
            end
        end
    end

endmodule

// File: verification/camera_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench top for the capture subsystem
// Clock and reset, LFSR Bayer frames, op-code tasks, test sequence
//////////////////////////////////////////////////////////////////////
`include "camera_macros.svh"

module camera_tb;

    localparam int FRAME_W      = 16;
    localparam int FRAME_H      = 12;
    localparam int LINE_BLANK   = 4;
    localparam int FRAME_BLANK  = 8;
    localparam int FRAME_CYCLES = 1 + FRAME_H * (FRAME_W + LINE_BLANK) + FRAME_BLANK;
    localparam int READ_CYCLES  = 64 * 4 + 8;
    // Eight frame lengths plus three read passes and a margin
    localparam int CYCLE_LIMIT  = 8 * FRAME_CYCLES + 3 * READ_CYCLES + 500;

    logic clock_spi_in = 1'b0;
    logic mipi_byte_reset_n;
    camera_pkg::raw_stream_t raw;
    logic [7:0]  op_code;
    logic        op_code_valid;
    logic [7:0]  operand;
    logic        operand_valid;
    logic [1:0]  operand_count;
    logic [7:0]  response;
    logic        response_valid;
    logic        check_req;
    logic [7:0]  check_kind;
    int          check_index;
    int          ref_frame;
    logic        test_end;
    int          test_id;
    int          error_count;
    int          check_count;
    int          tests_failed;
    int          cycle_count = 0;
    logic [23:0] lfsr_state = 24'd95485;
    logic [7:0]  resp;

    always #5 clock_spi_in = ~clock_spi_in;

    camera_top u_dut (
        .clock_spi_in, .mipi_byte_reset_n, .raw_i(raw),
        .op_code_i(op_code), .op_code_valid_i(op_code_valid), .operand_i(operand),
        .operand_valid_i(operand_valid), .operand_count_i(operand_count),
        .response_o(response), .response_valid_o(response_valid)
    );

    camera_checker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_chk (
        .clock_spi_in, .mipi_byte_reset_n, .raw_i(raw), .op_code_valid_i(op_code_valid),
        .response_i(response), .response_valid_i(response_valid),
        .check_req_i(check_req), .check_kind_i(check_kind), .check_index_i(check_index),
        .ref_frame_i(ref_frame), .test_end_i(test_end), .test_id_i(test_id),
        .error_count_o(error_count), .check_count_o(check_count),
        .tests_failed_o(tests_failed)
    );

    always @(posedge clock_spi_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 24 23 22 17 and one step per pixel bit
    function automatic camera_pkg::raw_pixel_t next_pixel();
        camera_pkg::raw_pixel_t pix;
        logic fb;
        pix = '0;
        for (int b = 0; b < 10; b++) begin
            fb = lfsr_state[23] ^ lfsr_state[22] ^ lfsr_state[21] ^ lfsr_state[16];
            lfsr_state = {lfsr_state[22:0], fb};
            pix = {pix[8:0], fb};
        end
        return pix;
    endfunction

    task automatic send_frame();
        @(posedge clock_spi_in);
        raw.frame_valid <= 1'b1;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                @(posedge clock_spi_in);
                raw.line_valid <= 1'b1;
                raw.pixel      <= next_pixel();
            end
            repeat (LINE_BLANK) begin
                @(posedge clock_spi_in);
                raw.line_valid <= 1'b0;
            end
        end
        raw.frame_valid <= 1'b0;
        repeat (FRAME_BLANK) @(posedge clock_spi_in);
    endtask

    task automatic issue_capture();
        @(posedge clock_spi_in);
        op_code       <= `OP_CAPTURE;
        op_code_valid <= 1'b1;
        @(posedge clock_spi_in);
        op_code_valid <= 1'b0;
    endtask

    // One response op that is optionally handed to the checker
    task automatic run_op(input logic [7:0] code, input int index, input int frame,
                          input bit check, output logic [7:0] result);
        @(posedge clock_spi_in);
        op_code       <= code;
        operand_count <= index[1:0];
        op_code_valid <= 1'b1;
        @(negedge clock_spi_in);
        while (!response_valid) @(negedge clock_spi_in);
        result = response;
        @(posedge clock_spi_in);
        if (check) begin
            check_req   <= 1'b1;
            check_kind  <= code;
            check_index <= index;
            ref_frame   <= frame;
            @(posedge clock_spi_in);
            check_req   <= 1'b0;
        end
        op_code_valid <= 1'b0;
    endtask

    task automatic read_image(input int frame);
        @(posedge clock_spi_in);
        op_code       <= `OP_READ;
        op_code_valid <= 1'b1;
        @(negedge clock_spi_in);
        while (!response_valid) @(negedge clock_spi_in);
        // 64 advances walk the whole byte space so the address wraps to 0
        for (int i = 0; i < 64; i++) begin
            @(posedge clock_spi_in);
            if (i < `BIN_PIXELS * 3) begin
                check_req   <= 1'b1;
                check_kind  <= `OP_READ;
                check_index <= i;
                ref_frame   <= frame;
            end
            @(posedge clock_spi_in);
            check_req     <= 1'b0;
            operand_valid <= 1'b1;
            @(posedge clock_spi_in);
            operand_valid <= 1'b0;
            @(posedge clock_spi_in);                 // New byte in response two edges later
        end
        op_code_valid <= 1'b0;
    endtask

    task automatic wait_capture_done();
        logic [7:0] status;
        status = 8'd0;
        while (status != 8'd1) run_op(`OP_STATUS, 0, 0, 1'b0, status);
    endtask

    task automatic finish_test(input int id);
        @(posedge clock_spi_in);
        test_end <= 1'b1;
        test_id  <= id;
        @(posedge clock_spi_in);
        test_end <= 1'b0;
    endtask

    initial begin
        raw = '0;
        op_code = '0;
        op_code_valid = 1'b0;
        operand = '0;
        operand_valid = 1'b0;
        operand_count = '0;
        check_req = 1'b0;
        check_kind = '0;
        check_index = 0;
        ref_frame = 0;
        test_end = 1'b0;
        test_id = 0;
        mipi_byte_reset_n = 1'b0;
        repeat (3) @(posedge clock_spi_in);
        mipi_byte_reset_n <= 1'b1;

        repeat (20) @(posedge clock_spi_in);         // Idle with no response allowed
        run_op(`OP_STATUS, 0, 0, 1'b1, resp);
        finish_test(1);

        issue_capture();
        run_op(`OP_STATUS, 0, 0, 1'b1, resp);        // Armed but not done
        send_frame();                                // Frame 0
        wait_capture_done();
        run_op(`OP_SIZE, 0, 0, 1'b1, resp);
        read_image(0);
        finish_test(2);

        for (int c = 0; c < 3; c++) run_op(`OP_METER, c, 0, 1'b1, resp);
        finish_test(3);

        send_frame();                                // Frame 1 is not captured
        read_image(0);
        for (int c = 0; c < 3; c++) run_op(`OP_METER, c, 1, 1'b1, resp);
        finish_test(4);

        fork
            send_frame();                            // Frame 2 is skipped
            begin
                repeat (20) @(posedge clock_spi_in);
                issue_capture();
            end
        join
        send_frame();                                // Frame 3
        wait_capture_done();
        run_op(`OP_SIZE, 0, 3, 1'b1, resp);
        read_image(3);
        finish_test(5);

        repeat (2) @(posedge clock_spi_in);
        $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/camera_pkg.sv
design/camera_crop.sv
design/bayer_binning.sv
design/exposure_metering.sv
design/pixel_packer.sv
design/image_buffer.sv
design/capture_control.sv
design/camera_top.sv
verification/camera_checker.sv
verification/camera_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the capture subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f src.f --top-module camera_tb -o camera_sim
./obj_dir/camera_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
